// ==== uncached_lsu_config.svh ====
// Uncached LSU widths
`ifndef UNCACHED_LSU_CONFIG_SVH
`define UNCACHED_LSU_CONFIG_SVH

// Data and address width
`define LSU_XLEN 64

// One strobe bit per byte of a beat
`define LSU_STRB_W 8

// Byte offset within a beat
`define LSU_OFS_W 3

`endif

// ==== lsu_pkg.sv ====
// Memory operation types
`default_nettype none

package lsu_pkg;

    typedef enum logic [1:0] {
        MEM_LOAD  = 2'b00,
        MEM_STORE = 2'b01,
        MEM_AMO   = 2'b10
    } mem_op_e;

    // Access size, log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10,
        SIZE_D = 2'b11
    } size_e;

    // Upper five bits of funct7
    typedef enum logic [4:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_fn_e;

endpackage

`default_nettype wire

// ==== exc_pkg.sv ====
// Exception causes
`default_nettype none

package exc_pkg;

    // RISC-V mcause codes for the LSU traps
    typedef enum logic [3:0] {
        EXC_LOAD_MISALIGN  = 4'd4,
        EXC_STORE_MISALIGN = 4'd6   // Also for AMOs
    } exc_cause_e;

endpackage

`default_nettype wire

// ==== lsu_ctrl.sv ====
// LSU control FSM
`timescale 1ns/1ns
`default_nettype none
`include "uncached_lsu_config.svh"

module lsu_ctrl (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     req_valid,
    input  wire lsu_pkg::mem_op_e   req_op,
    input  wire lsu_pkg::size_e     req_size,
    input  wire                     req_unsigned,
    input  wire [`LSU_XLEN-1:0]     req_addr,
    input  wire                     ar_ready,
    input  wire                     r_valid,
    input  wire                     aw_ready,
    input  wire                     w_ready,
    input  wire                     b_valid,
    input  wire [`LSU_XLEN-1:0]     load_data,
    output logic                    req_ready,
    output logic                    accept,
    output logic                    amo_load,
    output lsu_pkg::size_e          ld_size,
    output logic                    ld_unsigned,
    output logic                    ar_valid,
    output logic                    aw_valid,
    output logic                    w_valid,
    output logic [`LSU_XLEN-1:0]    bus_addr,
    output logic                    resp_valid,
    output logic [`LSU_XLEN-1:0]    resp_value,
    output logic                    ex_valid,
    output exc_pkg::exc_cause_e     ex_cause,
    output logic [`LSU_XLEN-1:0]    ex_tval
);
    import lsu_pkg::*;
    import exc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_R,  // AR issued, waiting for R
        ST_AMO,     // ALU step and write data setup
        ST_WAIT_W   // AW and W issued, waiting for B
    } state_e;

    state_e  state;
    mem_op_e op_q;
    logic    aligned;

    always_comb begin
        unique case (req_size)
            SIZE_B:  aligned = 1'b1;
            SIZE_H:  aligned = req_addr[0] == 1'b0;
            SIZE_W:  aligned = req_addr[1:0] == 2'b00;
            default: aligned = req_addr[`LSU_OFS_W-1:0] == '0;
        endcase
    end

    assign req_ready = state == ST_IDLE;
    assign accept    = req_valid && req_ready;
    assign amo_load  = state == ST_AMO;

    // AMO reads are full signed words or doublewords
    assign ld_size     = (req_op == MEM_AMO && req_size != SIZE_W) ? SIZE_D : req_size;
    assign ld_unsigned = req_unsigned && req_op != MEM_AMO;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= ST_IDLE;
            ar_valid   <= 1'b0;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            resp_valid <= 1'b0;
            ex_valid   <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            ex_valid   <= 1'b0;
            unique case (state)
                ST_IDLE: begin
                    if (accept) begin
                        if (!aligned) begin
                            ex_valid <= 1'b1;  // Trap, stay idle
                        end else if (req_op == MEM_STORE) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= ST_WAIT_W;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= ST_WAIT_R;
                        end
                    end
                end
                ST_WAIT_R: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (r_valid) begin
                        if (op_q == MEM_AMO) begin
                            state <= ST_AMO;
                        end else begin
                            resp_valid <= 1'b1;
                            state      <= ST_IDLE;
                        end
                    end
                end
                ST_AMO: begin
                    aw_valid <= 1'b1;
                    w_valid  <= 1'b1;
                    state    <= ST_WAIT_W;
                end
                ST_WAIT_W: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (b_valid) begin
                        resp_valid <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= req_op;
            bus_addr <= req_addr;
        end
        if (accept && !aligned) begin
            ex_cause <= (req_op == MEM_LOAD) ? EXC_LOAD_MISALIGN : EXC_STORE_MISALIGN;
            ex_tval  <= req_addr;
        end
        // Loaded value stays put for the AMO write-back
        if (state == ST_WAIT_R && r_valid) begin
            resp_value <= load_data;
        end
        if (state == ST_WAIT_W && b_valid && op_q == MEM_STORE) begin
            resp_value <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== load_aligner.sv ====
// Load data extraction
`timescale 1ns/1ns
`default_nettype none
`include "uncached_lsu_config.svh"

module load_aligner (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     accept,
    input  wire [`LSU_OFS_W-1:0]    req_addr,
    input  wire lsu_pkg::size_e     req_size,
    input  wire                     req_unsigned,
    input  wire [`LSU_XLEN-1:0]     r_data,
    output logic [`LSU_XLEN-1:0]    load_data
);
    import lsu_pkg::*;

    logic [`LSU_OFS_W-1:0] ofs_q;
    size_e                 size_q;
    logic                  unsigned_q;
    logic [7:0]            byte_sel;
    logic [15:0]           half_sel;
    logic [31:0]           word_sel;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ofs_q      <= '0;
            size_q     <= SIZE_D;
            unsigned_q <= 1'b0;
        end else if (accept) begin
            ofs_q      <= req_addr;
            size_q     <= req_size;
            unsigned_q <= req_unsigned;
        end
    end

    assign byte_sel = r_data[{ofs_q, 3'b000} +: 8];
    assign half_sel = r_data[{ofs_q[2:1], 4'b0000} +: 16];
    assign word_sel = r_data[{ofs_q[2], 5'b00000} +: 32];

    always_comb begin
        unique case (size_q)
            SIZE_B: load_data = {{(`LSU_XLEN-8){~unsigned_q & byte_sel[7]}}, byte_sel};
            SIZE_H: load_data = {{(`LSU_XLEN-16){~unsigned_q & half_sel[15]}}, half_sel};
            SIZE_W: load_data = {{(`LSU_XLEN-32){~unsigned_q & word_sel[31]}}, word_sel};
            default: load_data = r_data;  // Doubleword, no extension
        endcase
    end

endmodule

`default_nettype wire

// ==== store_aligner.sv ====
// Store data and strobe alignment
`timescale 1ns/1ns
`default_nettype none
`include "uncached_lsu_config.svh"

module store_aligner (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     accept,
    input  wire                     amo_load,
    input  wire [`LSU_OFS_W-1:0]    req_addr,
    input  wire lsu_pkg::size_e     req_size,
    input  wire [`LSU_XLEN-1:0]     req_value,
    input  wire [`LSU_XLEN-1:0]     amo_result,
    output logic [`LSU_XLEN-1:0]    w_data,
    output logic [`LSU_STRB_W-1:0]  w_strb
);
    import lsu_pkg::*;

    logic [`LSU_OFS_W-1:0] ofs_q;
    size_e                 size_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ofs_q  <= '0;
            size_q <= SIZE_D;
        end else if (accept) begin
            ofs_q  <= req_addr;
            size_q <= req_size;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            w_data <= req_value << {req_addr, 3'b000};
        end else if (amo_load) begin
            w_data <= amo_result << {ofs_q, 3'b000};  // AMO write-back
        end
    end

    always_comb begin
        unique case (size_q)
            SIZE_B:  w_strb = `LSU_STRB_W'(8'h01) << ofs_q;
            SIZE_H:  w_strb = `LSU_STRB_W'(8'h03) << ofs_q;
            SIZE_W:  w_strb = `LSU_STRB_W'(8'h0f) << ofs_q;
            default: w_strb = '1;
        endcase
    end

endmodule

`default_nettype wire

// ==== amo_alu.sv ====
// AMO write-back ALU
`timescale 1ns/1ns
`default_nettype none
`include "uncached_lsu_config.svh"

module amo_alu (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     accept,
    input  wire lsu_pkg::amo_fn_e   req_amo,
    input  wire [`LSU_XLEN-1:0]     req_value,
    input  wire lsu_pkg::size_e     req_size,
    input  wire [`LSU_XLEN-1:0]     original,
    output logic [`LSU_XLEN-1:0]    amo_result
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] operand_q;
    amo_fn_e              fn_q;
    logic                 lt_s;
    logic                 lt_u;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            operand_q <= '0;
            fn_q      <= AMO_ADD;
        end else if (accept) begin
            // Word operand compares like the sign-extended load
            operand_q <= (req_size == SIZE_W) ?
                         {{(`LSU_XLEN-32){req_value[31]}}, req_value[31:0]} : req_value;
            fn_q      <= req_amo;
        end
    end

    assign lt_s = $signed(original) < $signed(operand_q);
    assign lt_u = original < operand_q;

    always_comb begin
        unique case (fn_q)
            AMO_SWAP: amo_result = operand_q;
            AMO_ADD:  amo_result = original + operand_q;
            AMO_XOR:  amo_result = original ^ operand_q;
            AMO_AND:  amo_result = original & operand_q;
            AMO_OR:   amo_result = original | operand_q;
            AMO_MIN:  amo_result = lt_s ? original : operand_q;
            AMO_MAX:  amo_result = lt_s ? operand_q : original;
            AMO_MINU: amo_result = lt_u ? original : operand_q;
            default:  amo_result = lt_u ? operand_q : original;  // maxu
        endcase
    end

endmodule

`default_nettype wire

// ==== uncached_lsu.sv ====
// Uncached load/store unit
`timescale 1ns/1ns
`default_nettype none
`include "uncached_lsu_config.svh"

module uncached_lsu (
    input  wire                     clk,
    input  wire                     rstn,
    // CPU side
    input  wire                     req_valid,
    output logic                    req_ready,
    input  wire lsu_pkg::mem_op_e   req_op,
    input  wire lsu_pkg::size_e     req_size,
    input  wire                     req_unsigned,
    input  wire lsu_pkg::amo_fn_e   req_amo,
    input  wire [`LSU_XLEN-1:0]     req_addr,
    input  wire [`LSU_XLEN-1:0]     req_value,
    output logic                    resp_valid,
    output logic [`LSU_XLEN-1:0]    resp_value,
    output logic                    ex_valid,
    output exc_pkg::exc_cause_e     ex_cause,
    output logic [`LSU_XLEN-1:0]    ex_tval,
    // Memory side, single beats
    output logic                    ar_valid,
    input  wire                     ar_ready,
    output logic [`LSU_XLEN-1:0]    ar_addr,
    input  wire                     r_valid,
    input  wire [`LSU_XLEN-1:0]     r_data,
    output logic                    aw_valid,
    input  wire                     aw_ready,
    output logic [`LSU_XLEN-1:0]    aw_addr,
    output logic                    w_valid,
    input  wire                     w_ready,
    output logic [`LSU_XLEN-1:0]    w_data,
    output logic [`LSU_STRB_W-1:0]  w_strb,
    input  wire                     b_valid
);
    import lsu_pkg::*;

    logic                 accept;
    logic                 amo_load;
    size_e                ld_size;
    logic                 ld_unsigned;
    logic [`LSU_XLEN-1:0] load_data;
    logic [`LSU_XLEN-1:0] amo_result;
    logic [`LSU_XLEN-1:0] bus_addr;

    assign ar_addr = bus_addr;
    assign aw_addr = bus_addr;

    lsu_ctrl u_ctrl (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_op(req_op), .req_size(req_size),
        .req_unsigned(req_unsigned), .req_addr(req_addr),
        .ar_ready(ar_ready), .r_valid(r_valid), .aw_ready(aw_ready),
        .w_ready(w_ready), .b_valid(b_valid), .load_data(load_data),
        .req_ready(req_ready), .accept(accept), .amo_load(amo_load),
        .ld_size(ld_size), .ld_unsigned(ld_unsigned),
        .ar_valid(ar_valid), .aw_valid(aw_valid), .w_valid(w_valid),
        .bus_addr(bus_addr), .resp_valid(resp_valid), .resp_value(resp_value),
        .ex_valid(ex_valid), .ex_cause(ex_cause), .ex_tval(ex_tval)
    );

    load_aligner u_load (
        .clk(clk), .rstn(rstn), .accept(accept),
        .req_addr(req_addr[`LSU_OFS_W-1:0]), .req_size(ld_size),
        .req_unsigned(ld_unsigned), .r_data(r_data), .load_data(load_data)
    );

    store_aligner u_store (
        .clk(clk), .rstn(rstn), .accept(accept), .amo_load(amo_load),
        .req_addr(req_addr[`LSU_OFS_W-1:0]), .req_size(req_size),
        .req_value(req_value), .amo_result(amo_result),
        .w_data(w_data), .w_strb(w_strb)
    );

    // Original value is the registered load response
    amo_alu u_amo (
        .clk(clk), .rstn(rstn), .accept(accept), .req_amo(req_amo),
        .req_value(req_value), .req_size(req_size), .original(resp_value),
        .amo_result(amo_result)
    );

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
// Testbench bus memory
`timescale 1ns/1ns
`default_nettype none
`include "uncached_lsu_config.svh"

module tb_axi_mem (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     ar_valid,
    output logic                    ar_ready,
    input  wire [`LSU_XLEN-1:0]     ar_addr,
    output logic                    r_valid,
    output logic [`LSU_XLEN-1:0]    r_data,
    input  wire                     aw_valid,
    output logic                    aw_ready,
    input  wire [`LSU_XLEN-1:0]     aw_addr,
    input  wire                     w_valid,
    output logic                    w_ready,
    input  wire [`LSU_XLEN-1:0]     w_data,
    input  wire [`LSU_STRB_W-1:0]   w_strb,
    output logic                    b_valid
);
    logic [`LSU_XLEN-1:0]   mem [0:31];  // 32 doublewords
    logic [31:0]            lfsr = 32'hf9c9;
    logic [4:0]             rd_idx;
    logic [4:0]             wr_idx;
    logic [`LSU_XLEN-1:0]   wr_data;
    logic [`LSU_STRB_W-1:0] wr_strb;
    logic                   rd_pend;
    logic                   aw_got;
    logic                   w_got;
    logic [1:0]             ar_cnt;
    logic [1:0]             rd_cnt;
    logic [1:0]             aw_cnt;
    logic [1:0]             w_cnt;
    logic [1:0]             b_cnt;
    int                     i;

    // Two LFSR steps, one per delay bit
    function automatic logic [1:0] next_delay();
        logic [1:0] d;
        d = '0;
        repeat (2) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            d = {d[0], lfsr[0]};
        end
        return d;
    endfunction

    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        for (i = 0; i < 256; i++) begin
            mem[i / 8][8 * (i % 8) +: 8] = 8'(i * 37 + 11);  // Every address bit matters
        end
    end

    always @(negedge clk or negedge rstn) begin
        if (!rstn) begin
            ar_ready = 1'b0;
            r_valid  = 1'b0;
            aw_ready = 1'b0;
            w_ready  = 1'b0;
            b_valid  = 1'b0;
            rd_pend  = 1'b0;
            aw_got   = 1'b0;
            w_got    = 1'b0;
            ar_cnt   = next_delay();
            aw_cnt   = next_delay();
            w_cnt    = next_delay();
            b_cnt    = next_delay();
        end else begin
            if (ar_ready) begin
                ar_ready = 1'b0;
                rd_pend  = 1'b1;
                rd_cnt   = next_delay();
            end else if (ar_valid && !rd_pend) begin
                if (ar_cnt == 2'd0) begin
                    ar_ready = 1'b1;
                    rd_idx   = ar_addr[7:3];
                    ar_cnt   = next_delay();
                end else begin
                    ar_cnt = ar_cnt - 2'd1;
                end
            end
            r_valid = 1'b0;  // Single beat, no r_ready
            if (rd_pend) begin
                if (rd_cnt == 2'd0) begin
                    r_valid = 1'b1;
                    r_data  = mem[rd_idx];
                    rd_pend = 1'b0;
                end else begin
                    rd_cnt = rd_cnt - 2'd1;
                end
            end
            if (aw_ready) begin
                aw_ready = 1'b0;
                aw_got   = 1'b1;
            end else if (aw_valid && !aw_got) begin
                if (aw_cnt == 2'd0) begin
                    aw_ready = 1'b1;
                    wr_idx   = aw_addr[7:3];
                    aw_cnt   = next_delay();
                end else begin
                    aw_cnt = aw_cnt - 2'd1;
                end
            end
            if (w_ready) begin
                w_ready = 1'b0;
                w_got   = 1'b1;
            end else if (w_valid && !w_got) begin
                if (w_cnt == 2'd0) begin
                    w_ready = 1'b1;
                    wr_data = w_data;
                    wr_strb = w_strb;
                    w_cnt   = next_delay();
                end else begin
                    w_cnt = w_cnt - 2'd1;
                end
            end
            b_valid = 1'b0;
            if (aw_got && w_got) begin
                if (b_cnt == 2'd0) begin
                    for (i = 0; i < 8; i++) begin
                        if (wr_strb[i]) begin
                            mem[wr_idx][8 * i +: 8] = wr_data[8 * i +: 8];
                        end
                    end
                    b_valid = 1'b1;
                    aw_got  = 1'b0;
                    w_got   = 1'b0;
                    b_cnt   = next_delay();
                end else begin
                    b_cnt = b_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_uncached_lsu.sv ====
// Uncached LSU testbench
`timescale 1ns/1ns
`default_nettype none
`include "uncached_lsu_config.svh"

module tb_uncached_lsu;
    import lsu_pkg::*;
    import exc_pkg::*;

    localparam logic [`LSU_XLEN-1:0] BASE = 64'h8000_0000;
    localparam int NUM_REQ = 600;
    localparam int TIMEOUT = 40;

    logic                   clk = 1'b0;
    logic                   rstn;
    logic                   req_valid;
    logic                   req_ready;
    mem_op_e                req_op;
    size_e                  req_size;
    logic                   req_unsigned;
    amo_fn_e                req_amo;
    logic [`LSU_XLEN-1:0]   req_addr;
    logic [`LSU_XLEN-1:0]   req_value;
    logic                   resp_valid;
    logic [`LSU_XLEN-1:0]   resp_value;
    logic                   ex_valid;
    exc_cause_e             ex_cause;
    logic [`LSU_XLEN-1:0]   ex_tval;
    logic                   ar_valid;
    logic                   ar_ready;
    logic [`LSU_XLEN-1:0]   ar_addr;
    logic                   r_valid;
    logic [`LSU_XLEN-1:0]   r_data;
    logic                   aw_valid;
    logic                   aw_ready;
    logic [`LSU_XLEN-1:0]   aw_addr;
    logic                   w_valid;
    logic                   w_ready;
    logic [`LSU_XLEN-1:0]   w_data;
    logic [`LSU_STRB_W-1:0] w_strb;
    logic                   b_valid;

    logic [7:0]  model [0:255];  // Byte image of the memory region
    logic [31:0] lfsr = 32'hf9c9;
    int          checks = 0;
    int          errors = 0;
    int          hold_errors = 0;
    logic        timed_out = 1'b0;
    logic        ar_hold = 1'b0;
    logic        aw_hold = 1'b0;
    logic        w_hold = 1'b0;

    uncached_lsu u_dut (.*);
    tb_axi_mem u_mem (.*);

    always #4 clk = ~clk;

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        repeat (n) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [63:0] model_read(input logic [7:0] ofs, input size_e size,
                                               input logic uns);
        logic [63:0] v;
        int          n;
        v = '0;
        n = 1 << size;
        for (int k = 0; k < n; k++) begin
            v[8 * k +: 8] = model[ofs + 8'(k)];
        end
        if (!uns && n < 8 && v[8 * n - 1]) begin
            v = v | ~((64'd1 << (8 * n)) - 64'd1);  // Sign fill
        end
        return v;
    endfunction

    function automatic void model_write(input logic [7:0] ofs, input size_e size,
                                        input logic [63:0] data);
        for (int k = 0; k < (1 << size); k++) begin
            model[ofs + 8'(k)] = data[8 * k +: 8];
        end
    endfunction

    function automatic logic [63:0] amo_model(input amo_fn_e fn, input size_e size,
                                              input logic [63:0] old, input logic [63:0] value);
        logic [63:0] b;
        b = (size == SIZE_W) ? {{32{value[31]}}, value[31:0]} : value;
        case (fn)
            AMO_SWAP: return b;
            AMO_ADD:  return old + b;
            AMO_XOR:  return old ^ b;
            AMO_AND:  return old & b;
            AMO_OR:   return old | b;
            AMO_MIN:  return ($signed(old) < $signed(b)) ? old : b;
            AMO_MAX:  return ($signed(old) > $signed(b)) ? old : b;
            AMO_MINU: return (old < b) ? old : b;
            default:  return (old > b) ? old : b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_memory();
        checks++;
        for (int a = 0; a < 256; a++) begin
            assert (u_mem.mem[a / 8][8 * (a % 8) +: 8] === model[a]) else begin
                errors++;
                $display("[FAIL] %0t mem byte %0d: got %h, expected %h", $time, a,
                         u_mem.mem[a / 8][8 * (a % 8) +: 8], model[a]);
            end
        end
    endtask

    task automatic run_request(input mem_op_e op, input size_e size, input logic uns,
                               input amo_fn_e fn, input logic [7:0] ofs,
                               input logic [63:0] value);
        logic [63:0] old;
        logic [7:0]  strb;
        logic        misaligned;
        int          cycles;
        misaligned = (ofs & 8'((1 << size) - 1)) != 8'd0;
        strb = 8'(((1 << (1 << size)) - 1) << ofs[2:0]);
        assert (req_ready) else begin
            errors++;
            $display("Unit was not ready for a new request at %0t", $time);
        end
        req_valid    = 1'b1;
        req_op       = op;
        req_size     = size;
        req_unsigned = uns;
        req_amo      = fn;
        req_addr     = BASE + 64'(ofs);
        req_value    = value;
        @(negedge clk);
        req_valid = 1'b0;
        cycles = 0;
        while (!resp_valid && !ex_valid && cycles < TIMEOUT) begin
            assert (!req_ready) else begin
                errors++;
                $display("req_ready went high before the response at %0t", $time);
            end
            if (ar_valid) begin
                check_value("ar_addr", ar_addr, BASE + 64'(ofs));
            end
            if (aw_valid) begin
                check_value("aw_addr", aw_addr, BASE + 64'(ofs));
            end
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout after %0d cycles without response or exception", TIMEOUT);
        end else if (misaligned) begin
            assert (ex_valid && !resp_valid) else begin
                errors++;
                $display("Misaligned address %h gave no exception", req_addr);
            end
            check_value("ex_cause", ex_cause,
                        (op == MEM_LOAD) ? EXC_LOAD_MISALIGN : EXC_STORE_MISALIGN);
            check_value("ex_tval", ex_tval, BASE + 64'(ofs));
            repeat (2) begin
                assert (!ar_valid && !aw_valid) else begin
                    errors++;
                    $display("Bus request issued after a misaligned access at %0t", $time);
                end
                @(negedge clk);
            end
        end else begin
            assert (resp_valid && !ex_valid) else begin
                errors++;
                $display("Aligned address %h raised an exception", req_addr);
            end
            if (op == MEM_LOAD) begin
                check_value("resp_value", resp_value, model_read(ofs, size, uns));
            end else if (op == MEM_STORE) begin
                check_value("resp_value", resp_value, 64'd0);
                check_value("w_strb", w_strb, strb);
                model_write(ofs, size, value);
            end else begin
                old = model_read(ofs, size, 1'b0);  // AMO reads are signed
                check_value("resp_value", resp_value, old);
                check_value("w_strb", w_strb, strb);
                model_write(ofs, size, amo_model(fn, size, old, value));
            end
        end
        compare_memory();
    endtask

    // Bus valids hold until ready
    always @(posedge clk) begin
        if (rstn) begin
            assert (!ar_hold || ar_valid) else begin
                hold_errors++;
                $display("ar_valid dropped before ar_ready at %0t", $time);
            end
            assert (!aw_hold || aw_valid) else begin
                hold_errors++;
                $display("aw_valid dropped before aw_ready at %0t", $time);
            end
            assert (!w_hold || w_valid) else begin
                hold_errors++;
                $display("w_valid dropped before w_ready at %0t", $time);
            end
        end
        ar_hold = rstn && ar_valid && !ar_ready;
        aw_hold = rstn && aw_valid && !aw_ready;
        w_hold  = rstn && w_valid && !w_ready;
    end

    initial begin
        mem_op_e     op;
        size_e       size;
        amo_fn_e     fn;
        logic        uns;
        logic [7:0]  ofs;
        logic [63:0] value;
        int          k;
        int          count;
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_op       = MEM_LOAD;
        req_size     = SIZE_B;
        req_unsigned = 1'b0;
        req_amo      = AMO_ADD;
        req_addr     = '0;
        req_value    = '0;
        count        = 0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_value("req_ready", req_ready, 64'd1);
        check_value("resp_valid", resp_valid, 64'd0);
        check_value("ex_valid", ex_valid, 64'd0);
        check_value("ar_valid", ar_valid, 64'd0);
        check_value("aw_valid", aw_valid, 64'd0);
        check_value("w_valid", w_valid, 64'd0);
        for (k = 0; k < 256; k++) begin
            model[k] = u_mem.mem[k / 8][8 * (k % 8) +: 8];
        end
        while (count < NUM_REQ && !timed_out) begin
            op   = mem_op_e'(2'(rand_bits(2) % 3));
            size = size_e'(2'(rand_bits(2)));
            if (op == MEM_AMO) begin
                size = rand_bits(1) != 0 ? SIZE_D : SIZE_W;
            end
            uns = 1'(rand_bits(1));
            k   = int'(rand_bits(4) % 9);
            fn  = (k == 8) ? AMO_SWAP : amo_fn_e'(5'(k << 2));
            ofs = 8'(rand_bits(8));
            if (rand_bits(3) != 0) begin
                ofs = ofs & ~8'((1 << size) - 1);  // Mostly aligned
            end
            value = rand_bits(64);
            run_request(op, size, uns, fn, ofs, value);
            count++;
        end
        $display("Requests: %0d  checks: %0d  errors: %0d", count, checks,
                 errors + hold_errors);
        if (errors + hold_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uncached_lsu.f ====
+incdir+.
lsu_pkg.sv
exc_pkg.sv
lsu_ctrl.sv
load_aligner.sv
store_aligner.sv
amo_alu.sv
uncached_lsu.sv
tb_axi_mem.sv
tb_uncached_lsu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the uncached LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f uncached_lsu.f --top-module tb_uncached_lsu -o tb_uncached_lsu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_uncached_lsu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
